/* tb.f */
verilog/kw_scan_pkg.sv
verilog/apb_ctrl_regs.sv
verilog/stream_context.sv
verilog/keyword_dfa.sv
verilog/packet_match_tally.sv
verilog/kw_scan_top.sv
tests/tb_clk_gen.sv
tests/tb_kw_scan.sv

/* run.sh */
#!/bin/sh
# Compile the keyword scanner testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_kw_scan \
   -f tb.f -o sim_kw_scan

# The simulator exits nonzero on a failed check, the search below decides
out=$(./obj_dir/sim_kw_scan 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q '^RESULT: PASS$'
then
   exit 0
fi
exit 1

/* tests/tb_kw_scan.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_kw_scan
   import kw_scan_pkg::*;
();

   localparam int APB_TIMEOUT   = 16;
   localparam int RESET_TIMEOUT = 40;

   logic              clk;
   logic              rst_n;
   logic              sop;
   logic              eop;
   logic              char_vld;
   logic [CHAR_W-1:0] char_in;
   logic [SID_W-1:0]  stream_id;
   logic              new_stream;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [APB_AW-1:0] paddr;
   logic [APB_DW-1:0] pwdata;
   logic [APB_DW-1:0] prdata;
   logic              pready;
   logic              pslverr;
   logic              fired;

   // Reference model keeps the characters since the last match of each stream
   string                  hist [NUM_STREAMS];
   logic [NUM_STREAMS-1:0] model_en;
   // Stream has a saved entry in the DUT
   logic [NUM_STREAMS-1:0] saved;
   logic [COUNT_W-1:0]     model_count;
   int                     seed;
   int                     err_count;

   tb_clk_gen clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   kw_scan_top dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .sop        (sop),
      .eop        (eop),
      .char_vld   (char_vld),
      .char_in    (char_in),
      .stream_id  (stream_id),
      .new_stream (new_stream),
      .psel       (psel),
      .penable    (penable),
      .pwrite     (pwrite),
      .paddr      (paddr),
      .pwdata     (pwdata),
      .prdata     (prdata),
      .pready     (pready),
      .pslverr    (pslverr),
      .fired      (fired)
   );

   task automatic abort_run();
      err_count = err_count + 1;
      $display("RESULT: FAIL");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_count(input string name, input logic [COUNT_W-1:0] got,
                              input logic [COUNT_W-1:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_state_bit(input string name, input logic got, input logic exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_data(input string name, input logic [APB_DW-1:0] got,
                             input logic [APB_DW-1:0] exp);
      if (got !== exp)
      begin
         $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   // Packet matches when the keyword appears after the stream's last match
   // Only enabled streams keep their state
   function automatic logic model_packet(input logic [SID_W-1:0] sid, input logic new_s,
                                         input string text);
      string seen;
      int    pos;
      int    last_end;
      logic  found;
      seen     = new_s ? "" : hist[sid];
      seen     = {seen, text};
      pos      = 0;
      last_end = 0;
      found    = 1'b0;
      while (pos + KW_LEN <= seen.len())
      begin
         if (seen.substr(pos, pos + KW_LEN - 1) == "PASS")
         begin
            found    = 1'b1;
            pos      = pos + KW_LEN;
            last_end = pos;
         end
         else
            pos = pos + 1;
      end
      if (model_en[sid])
      begin
         hist[sid]  = (last_end >= seen.len()) ? "" : seen.substr(last_end, seen.len() - 1);
         saved[sid] = 1'b1;
         // Count sticks at all ones
         if (found && (model_count != '1))
            model_count = model_count + 1'b1;
      end
      return found;
   endfunction

   // One APB transfer with setup then access until pready
   task automatic apb_access(input logic wr, input logic [APB_AW-1:0] addr,
                             input logic [APB_DW-1:0] wdata, output logic [APB_DW-1:0] rdata);
      int waited;
      @(posedge clk);
      #1;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wr ? wdata : '0;
      // No ready in the setup phase
      @(negedge clk);
      check_state_bit("pready", pready, 1'b0);
      @(posedge clk);
      #1;
      penable = 1'b1;
      waited  = 0;
      @(negedge clk);
      while (!pready)
      begin
         waited = waited + 1;
         if (waited >= APB_TIMEOUT)
         begin
            $display("timeout: pready never rose for address 0x%h", addr);
            abort_run();
         end
         @(negedge clk);
      end
      check_state_bit("pslverr", pslverr, 1'b0);
      rdata = prdata;
      // Transfer completes on this edge
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
      logic [APB_DW-1:0] unused_rd;
      apb_access(1'b1, addr, data, unused_rd);
   endtask

   task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
      apb_access(1'b0, addr, '0, data);
   endtask

   task automatic expect_count(input logic [COUNT_W-1:0] exp);
      logic [APB_DW-1:0] rd;
      apb_read(REG_COUNT, rd);
      check_count("count", rd[COUNT_W-1:0], exp);
   endtask

   // Write both enable halves and read them back
   task automatic set_enables(input logic [APB_DW-1:0] lo, input logic [APB_DW-1:0] hi);
      logic [APB_DW-1:0] rd;
      apb_write(REG_EN_LO, lo);
      apb_write(REG_EN_HI, hi);
      model_en = {hi, lo};
      apb_read(REG_EN_LO, rd);
      check_data("en_lo", rd, lo);
      apb_read(REG_EN_HI, rd);
      check_data("en_hi", rd, hi);
   endtask

   // sop, characters with a gap after char i when gaps[i], then eop left driven
   task automatic send_packet(input logic [SID_W-1:0] sid, input logic new_s,
                              input string text, input logic [31:0] gaps);
      int i;
      @(posedge clk);
      #1;
      sop        = 1'b1;
      eop        = 1'b0;
      char_vld   = 1'b0;
      stream_id  = sid;
      new_stream = new_s;
      for (i = 0; i < text.len(); i++)
      begin
         @(posedge clk);
         #1;
         sop        = 1'b0;
         new_stream = 1'b0;
         char_vld   = 1'b1;
         char_in    = text[i];
         // Flag was cleared by the sop edge
         if (i == 0)
         begin
            @(negedge clk);
            check_state_bit("fired", fired, 1'b0);
         end
         if (gaps[i])
         begin
            @(posedge clk);
            #1;
            char_vld = 1'b0;
         end
      end
      @(posedge clk);
      #1;
      char_vld = 1'b0;
      eop      = 1'b1;
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      #1;
      sop      = 1'b0;
      eop      = 1'b0;
      char_vld = 1'b0;
   endtask

   // Single packet and an idle cycle with fired checked after eop
   task automatic run_packet(input logic [SID_W-1:0] sid, input logic new_s,
                             input string text, input logic [31:0] gaps);
      logic exp_match;
      exp_match = model_packet(sid, new_s, text);
      send_packet(sid, new_s, text, gaps);
      idle_cycle();
      @(negedge clk);
      // Disabled streams drop the flag at eop
      check_state_bit("fired", fired, exp_match && model_en[sid]);
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while (rst_n !== 1'b1)
      begin
         if (cycles >= RESET_TIMEOUT)
         begin
            $display("timeout: reset was never released");
            abort_run();
         end
         @(posedge clk);
         cycles = cycles + 1;
      end
   endtask

   task automatic test_reset_values();
      logic [APB_DW-1:0] rd;
      @(negedge clk);
      check_state_bit("fired", fired, 1'b0);
      expect_count('0);
      apb_read(REG_EN_LO, rd);
      check_data("en_lo", rd, '0);
      apb_read(REG_EN_HI, rd);
      check_data("en_hi", rd, '0);
      // Unmapped address
      apb_read(8'h0c, rd);
      check_data("prdata unmapped", rd, '0);
   endtask

   task automatic test_single_packet();
      set_enables(32'h0000_0008, 32'h0000_0000);
      run_packet(6'd3, 1'b1, "xxPASSyy", 32'h0);
      expect_count(16'd1);
      // Stream 40 is disabled
      run_packet(6'd40, 1'b1, "xxPASSyy", 32'h0);
      expect_count(16'd1);
   endtask

   task automatic test_split_packets();
      set_enables(32'h0000_0028, 32'h0000_0000);
      run_packet(6'd5, 1'b1, "PA", 32'h0);
      run_packet(6'd5, 1'b0, "SS", 32'h0);
      expect_count(16'd2);
      // Fresh stream on the second half loses the prefix
      run_packet(6'd5, 1'b1, "PA", 32'h0);
      run_packet(6'd5, 1'b1, "SS", 32'h0);
      expect_count(16'd2);
   endtask

   task automatic test_interleave();
      logic m;
      set_enables(32'h0000_00a8, 32'h0000_0010);
      // Back to back packets with the next sop right after eop
      m = model_packet(6'd7, 1'b1, "xP");
      send_packet(6'd7, 1'b1, "xP", 32'h0);
      m = model_packet(6'd36, 1'b1, "zPA");
      send_packet(6'd36, 1'b1, "zPA", 32'h2);
      m = model_packet(6'd7, 1'b0, "AS");
      send_packet(6'd7, 1'b0, "AS", 32'h1);
      m = model_packet(6'd36, 1'b0, "S");
      send_packet(6'd36, 1'b0, "S", 32'h0);
      m = model_packet(6'd7, 1'b0, "S");
      send_packet(6'd7, 1'b0, "S", 32'h0);
      idle_cycle();
      // Last packet completes the keyword of stream 7
      @(negedge clk);
      check_state_bit("fired", fired, m);
      expect_count(16'd3);
      run_packet(6'd36, 1'b0, "S", 32'h0);
      expect_count(16'd4);
   endtask

   task automatic test_fallback();
      set_enables(32'h0000_02a8, 32'h0000_0010);
      run_packet(6'd9, 1'b1, "PPASS", 32'h0);
      expect_count(16'd5);
      run_packet(6'd9, 1'b1, "PASPASS", 32'h55);
      expect_count(16'd6);
      // Two keywords in one packet count once
      run_packet(6'd9, 1'b1, "PASSPASS", 32'h0);
      expect_count(16'd7);
   endtask

   task automatic test_clear_and_random();
      string             alphabet;
      string             text;
      logic [SID_W-1:0]  sid;
      logic              new_s;
      logic [31:0]       gaps;
      logic [APB_DW-1:0] en_lo;
      logic [APB_DW-1:0] en_hi;
      int                r;
      int                n;
      int                i;
      int                len;
      int                c;
      alphabet = "PASSPAxS";
      apb_write(REG_COUNT, 32'hdead_beef);
      model_count = '0;
      expect_count('0);
      en_lo = $random(seed);
      en_hi = $random(seed);
      set_enables(en_lo, en_hi);
      for (n = 0; n < 40; n++)
      begin
         r = $random(seed);
         // Streams 0 to 3 and 32 to 35
         sid   = SID_W'((r & 3) + (((r >> 2) & 1) * 32));
         new_s = (((r >> 3) & 7) == 0) || !saved[sid];
         len   = 1 + ((r >> 6) & 7);
         gaps  = $random(seed);
         text  = "";
         for (i = 0; i < len; i++)
         begin
            c    = $random(seed) & 7;
            text = $sformatf("%s%s", text, alphabet.substr(c, c));
         end
         run_packet(sid, new_s, text, gaps);
         if ((n % 10) == 9)
            expect_count(model_count);
      end
      expect_count(model_count);
   endtask

   initial
   begin
      sop         = 1'b0;
      eop         = 1'b0;
      char_vld    = 1'b0;
      char_in     = '0;
      stream_id   = '0;
      new_stream  = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      model_en    = '0;
      saved       = '0;
      model_count = '0;
      err_count   = 0;
      seed        = 32'hcf5f_cd0b;
      wait_reset_release();
      test_reset_values();
      test_single_packet();
      test_split_packets();
      test_interleave();
      test_fallback();
      test_clear_and_random();
      if (err_count == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* tests/tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
   output logic clk,
   output logic rst_n
);

   // 10 ns period
   localparam int HALF_PERIOD  = 5;
   localparam int RESET_CYCLES = 10;

   initial
   begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // Release lines up with the stimulus offset after the edge
   initial
   begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;
   end

endmodule

`default_nettype wire

/* verilog/kw_scan_top.sv */
`timescale 1ns/10ps
`default_nettype none

module kw_scan_top
   import kw_scan_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   // Packet input
   input  logic              sop,
   input  logic              eop,
   input  logic              char_vld,
   input  logic [CHAR_W-1:0] char_in,
   input  logic [SID_W-1:0]  stream_id,
   input  logic              new_stream,
   // APB slave
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [APB_AW-1:0] paddr,
   input  logic [APB_DW-1:0] pwdata,
   output logic [APB_DW-1:0] prdata,
   output logic              pready,
   output logic              pslverr,
   // Packet held a match
   output logic              fired
);

   // Context to matcher
   logic [STATE_W-1:0]     restore_state;
   logic                   restore_vld;
   // Matcher to context and tally
   logic [STATE_W-1:0]     cur_state;
   logic                   hit;
   // Register block links
   logic [NUM_STREAMS-1:0] stream_en;
   logic [COUNT_W-1:0]     count;
   logic                   count_clr;

   // No error responses
   assign pslverr = 1'b0;

   stream_context u_stream_context (
      .clk           (clk),
      .rst_n         (rst_n),
      .sop           (sop),
      .eop           (eop),
      .stream_id     (stream_id),
      .new_stream    (new_stream),
      .stream_en     (stream_en),
      .cur_state     (cur_state),
      .restore_state (restore_state),
      .restore_vld   (restore_vld)
   );

   keyword_dfa u_keyword_dfa (
      .clk           (clk),
      .rst_n         (rst_n),
      .char_vld      (char_vld),
      .char_in       (char_in),
      .restore_state (restore_state),
      .restore_vld   (restore_vld),
      .cur_state     (cur_state),
      .hit           (hit)
   );

   packet_match_tally u_packet_match_tally (
      .clk       (clk),
      .rst_n     (rst_n),
      .sop       (sop),
      .eop       (eop),
      .stream_id (stream_id),
      .hit       (hit),
      .stream_en (stream_en),
      .count_clr (count_clr),
      .fired     (fired),
      .count     (count)
   );

   apb_ctrl_regs u_apb_ctrl_regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .stream_en (stream_en),
      .count_clr (count_clr),
      .count     (count)
   );

endmodule

`default_nettype wire

/* verilog/packet_match_tally.sv */
`timescale 1ns/10ps
`default_nettype none

module packet_match_tally
   import kw_scan_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   sop,
   input  logic                   eop,
   input  logic [SID_W-1:0]       stream_id,
   input  logic                   hit,
   input  logic [NUM_STREAMS-1:0] stream_en,
   input  logic                   count_clr,
   output logic                   fired,
   output logic [COUNT_W-1:0]     count
);

   // Enable bit of the stream in flight
   logic stream_on;
   // Packet matched, including a hit in the eop cycle
   logic pkt_match;
   // Count is pinned at all ones
   logic count_full;

   assign stream_on  = stream_en[stream_id];
   assign pkt_match  = fired || hit;
   assign count_full = &count;

   // Speculative per-packet match flag
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         fired <= 1'b0;
      end
      else if (sop)
      begin
         fired <= 1'b0;
      end
      else if (eop && !stream_on)
      begin
         // Disabled stream, drop the match
         fired <= 1'b0;
      end
      else if (hit)
      begin
         fired <= 1'b1;
      end
   end

   // Commit at eop
   // Software clear beats an increment
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         count <= '0;
      end
      else if (count_clr)
      begin
         count <= '0;
      end
      else if (eop && stream_on && pkt_match && !count_full)
      begin
         count <= count + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* verilog/keyword_dfa.sv */
`timescale 1ns/10ps
`default_nettype none

module keyword_dfa
   import kw_scan_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic               char_vld,
   input  logic [CHAR_W-1:0]  char_in,
   // Context load from the stream memory
   input  logic [STATE_W-1:0] restore_state,
   input  logic               restore_vld,
   output logic [STATE_W-1:0] cur_state,
   output logic               hit
);

   // Matched prefix length
   logic [STATE_W-1:0] state_q;
   // State the step starts from, restored or held
   logic [STATE_W-1:0] base_state;
   logic [STATE_W-1:0] next_state;
   logic               next_hit;

   // Keyword character at a given position
   // Positions past the keyword give zero
   function automatic logic [CHAR_W-1:0] kw_char(input logic [STATE_W-1:0] idx);
      if (idx >= KW_LEN)
      begin
         return '0;
      end
      return KEYWORD[(KW_LEN - 1 - int'(idx)) * CHAR_W +: CHAR_W];
   endfunction

   // Restored state wins over the held one
   assign base_state = restore_vld ? restore_state : state_q;

   always_comb
   begin
      next_state = base_state;
      next_hit   = 1'b0;
      if (char_vld)
      begin
         if ((base_state < KW_LEN) && (char_in == kw_char(base_state)))
         begin
            if (base_state == KW_LEN - 1)
            begin
               // Full keyword, report and start over
               next_state = '0;
               next_hit   = 1'b1;
            end
            else
            begin
               next_state = base_state + 1'b1;
            end
         end
         else if (char_in == kw_char('0))
         begin
            // Mismatch on a leading P, that P begins a new match
            next_state = STATE_W'(1);
         end
         else
         begin
            next_state = '0;
         end
      end
   end

   // One cycle from character to state and hit
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q <= '0;
         hit     <= 1'b0;
      end
      else
      begin
         state_q <= next_state;
         hit     <= next_hit;
      end
   end

   assign cur_state = state_q;

   // State is always a valid prefix length
   a_state_range: assert property (
      @(posedge clk) disable iff (!rst_n)
      cur_state <= KW_LEN
   ) else $error("matcher state out of range");

endmodule

`default_nettype wire

/* verilog/stream_context.sv */
`timescale 1ns/10ps
`default_nettype none

module stream_context
   import kw_scan_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   sop,
   input  logic                   eop,
   input  logic [SID_W-1:0]       stream_id,
   input  logic                   new_stream,
   input  logic [NUM_STREAMS-1:0] stream_en,
   // State after the last character, from the matcher
   input  logic [STATE_W-1:0]     cur_state,
   // State to load into the matcher
   output logic [STATE_W-1:0]     restore_state,
   output logic                   restore_vld
);

   // One saved matcher state per stream
   logic [STATE_W-1:0] state_mem [NUM_STREAMS];

   // Enable bit of the stream in flight
   logic stream_on;

   assign stream_on = stream_en[stream_id];

   // Save on eop
   // A disabled stream keeps its old entry
   always_ff @(posedge clk)
   begin
      if (eop && stream_on)
      begin
         state_mem[stream_id] <= cur_state;
      end
   end

   // Restore data, loaded at sop
   // New stream starts from an empty match
   always_ff @(posedge clk)
   begin
      if (sop)
      begin
         if (new_stream)
         begin
            restore_state <= '0;
         end
         else
         begin
            restore_state <= state_mem[stream_id];
         end
      end
   end

   // Load strobe, one cycle after sop
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         restore_vld <= 1'b0;
      end
      else
      begin
         restore_vld <= sop;
      end
   end

   // Packet framing: start and end cycles are distinct
   a_sop_eop_apart: assert property (
      @(posedge clk) disable iff (!rst_n)
      !(sop && eop)
   ) else $error("sop and eop in the same cycle");

endmodule

`default_nettype wire

/* verilog/apb_ctrl_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_ctrl_regs
   import kw_scan_pkg::*;
(
   input  logic                   clk,
   input  logic                   rst_n,
   // APB slave side
   input  logic                   psel,
   input  logic                   penable,
   input  logic                   pwrite,
   input  logic [APB_AW-1:0]      paddr,
   input  logic [APB_DW-1:0]      pwdata,
   output logic [APB_DW-1:0]      prdata,
   output logic                   pready,
   // Control toward the tally stage
   output logic [NUM_STREAMS-1:0] stream_en,
   output logic                   count_clr,
   input  logic [COUNT_W-1:0]     count
);

   // Enable bitmap, split over two registers
   logic [APB_DW-1:0] en_lo;
   logic [APB_DW-1:0] en_hi;

   // Access phase of a write, and of a read
   logic wr_access;
   logic rd_access;

   assign wr_access = psel && penable && pwrite;
   assign rd_access = psel && !pwrite;

   // No wait states, every access phase completes at once
   assign pready = psel && penable;

   // Low half covers streams 0 to 31
   assign stream_en = {en_hi, en_lo};

   // Clear strobe lasts one access phase only
   // Tally clears count on the edge that ends the access
   assign count_clr = wr_access && (paddr == REG_COUNT);

   // Enable register writes
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         en_lo <= '0;
         en_hi <= '0;
      end
      else if (wr_access)
      begin
         case (paddr)
            REG_EN_LO:
            begin
               en_lo <= pwdata;
            end
            REG_EN_HI:
            begin
               en_hi <= pwdata;
            end
            default:
            begin
               // Count clear is handled by the strobe, others ignored
            end
         endcase
      end
   end

   // Read mux, valid through setup and access phases
   always_comb
   begin
      prdata = '0;
      if (rd_access)
      begin
         case (paddr)
            REG_EN_LO:
            begin
               prdata = en_lo;
            end
            REG_EN_HI:
            begin
               prdata = en_hi;
            end
            REG_COUNT:
            begin
               // Count sits in the low bits
               prdata = APB_DW'(count);
            end
            default:
            begin
               // Unmapped addresses read back zero
               prdata = '0;
            end
         endcase
      end
   end

   // Access phase always follows a setup phase of the same transfer
   a_penable_needs_psel: assert property (
      @(posedge clk) disable iff (!rst_n)
      penable |-> psel
   ) else $error("penable high without psel");

endmodule

`default_nettype wire

/* verilog/kw_scan_pkg.sv */
`default_nettype none

package kw_scan_pkg;

   // Character stream
   localparam int CHAR_W = 8;

   // Keyword "PASS", first character in the top byte
   localparam int KW_LEN = 4;
   localparam logic [KW_LEN*CHAR_W-1:0] KEYWORD = {8'h50, 8'h41, 8'h53, 8'h53};

   // Matcher state counts matched characters, 0 to KW_LEN
   localparam int STATE_W = 3;

   // Stream ids
   localparam int SID_W = 6;
   localparam int NUM_STREAMS = 64;

   // Saturating match count
   localparam int COUNT_W = 16;

   // APB bus widths
   localparam int APB_AW = 8;
   localparam int APB_DW = 32;

   // Register map
   // Enable bits, streams 0 to 31
   localparam logic [APB_AW-1:0] REG_EN_LO = 8'h00;
   // Enable bits, streams 32 to 63
   localparam logic [APB_AW-1:0] REG_EN_HI = 8'h04;
   // Match count, any write clears it
   localparam logic [APB_AW-1:0] REG_COUNT = 8'h08;

endpackage

`default_nettype wire
